/* Bender.yml */
package:
  name: elevator

sources:
  - rtl/elevatorPkg.sv
  - rtl/hallCallRegister.sv
  - rtl/carCallRegister.sv
  - rtl/carController.sv
  - rtl/floorDisplay.sv
  - rtl/elevatorTop.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/elevatorTb_assert.sv
      - sim/elevatorTb.sv

/* rtl/carCallRegister.sv */
`timescale 1ns/1ps

module carCallRegister (
    input  logic                                clk_in,
    input  logic                                rst,
    input  logic [elevatorPkg::numFloors-1:0]   carButton,
    input  logic [elevatorPkg::floorWidth-1:0]  currentFloor,
    input  logic [elevatorPkg::floorWidth-1:0]  targetFloor,
    input  logic [elevatorPkg::dirWidth-1:0]    direction,
    input  logic                                busy,
    output logic [elevatorPkg::numFloors-1:0]   carPending
);

    // Cleared while a button is held low, set again once the line is back high
    logic [elevatorPkg::numFloors-1:0] armed;

    // Floors whose released button is taken as a call this cycle
    logic [elevatorPkg::numFloors-1:0] accept;

    // ----------------------------------------------------------------------
    // Acceptance rule, without a direction request from inside the car
    // ----------------------------------------------------------------------

    function automatic logic callAccepted(
        input logic [elevatorPkg::floorWidth-1:0] callFloor
    );
        logic idleOk;
        logic upOk;
        logic downOk;
        idleOk = (direction == elevatorPkg::dirIdle) && (currentFloor != callFloor);
        upOk   = (direction == elevatorPkg::dirUp) && (currentFloor < callFloor)
                 && (targetFloor >= callFloor);
        downOk = (direction == elevatorPkg::dirDown) && (currentFloor > callFloor)
                 && (targetFloor <= callFloor);
        return idleOk || upOk || downOk;
    endfunction

    always_comb begin
        for (int f = 0; f < elevatorPkg::numFloors; f++) begin
            // Only the first high cycle after a low period counts
            accept[f] = carButton[f] && !armed[f]
                        && callAccepted(elevatorPkg::floorWidth'(f));
        end
    end

    // ----------------------------------------------------------------------
    // Edge tracking and pending call bits
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            // Buttons idle high at reset, so nothing is taken until one is pressed
            armed      <= '1;
            carPending <= '0;
        end else begin
            // A release that is not accepted is dropped, not retried
            armed <= carButton;
            for (int f = 0; f < elevatorPkg::numFloors; f++) begin
                if (busy && (currentFloor == elevatorPkg::floorWidth'(f))) begin
                    carPending[f] <= 1'b0;
                end else if (accept[f]) begin
                    carPending[f] <= 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/carController.sv */
`timescale 1ns/1ps

module carController (
    input  logic                                clk_in,
    input  logic                                rst,
    input  logic [elevatorPkg::numFloors-1:0]   hallPending,
    input  logic [elevatorPkg::numFloors-1:0]   carPending,
    output logic [elevatorPkg::floorWidth-1:0]  currentFloor,
    output logic [elevatorPkg::floorWidth-1:0]  targetFloor,
    output logic [elevatorPkg::dirWidth-1:0]    direction,
    output logic                                busy
);

    // Every floor that has a call of either kind waiting
    logic [elevatorPkg::numFloors-1:0] pending;
    logic                              anyPending;

    // Lowest floor with a call, or the old target if there is none
    logic [elevatorPkg::floorWidth-1:0] lowestFloor;

    // High during the dwell period that follows each check cycle
    logic       dwelling;
    logic [7:0] dwellCount;

    assign pending    = hallPending | carPending;
    assign anyPending = |pending;

    // ----------------------------------------------------------------------
    // Target selection
    // ----------------------------------------------------------------------

    // Scan from the top down so the lowest pending floor is the last to win
    always_comb begin
        lowestFloor = targetFloor;
        for (int f = elevatorPkg::numFloors - 1; f >= 0; f--) begin
            if (pending[f]) begin
                lowestFloor = elevatorPkg::floorWidth'(f);
            end
        end
    end

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            targetFloor <= '0;
        end else begin
            targetFloor <= lowestFloor;
        end
    end

    // ----------------------------------------------------------------------
    // Direction state
    // ----------------------------------------------------------------------

    // Idle only once every call is served and the car has stopped at its target
    // Otherwise the sign of target minus floor picks the way
    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            direction <= elevatorPkg::dirIdle;
        end else begin
            if (!anyPending && !busy && (currentFloor == targetFloor)) begin
                direction <= elevatorPkg::dirIdle;
            end else if (targetFloor > currentFloor) begin
                direction <= elevatorPkg::dirUp;
            end else if (targetFloor < currentFloor) begin
                direction <= elevatorPkg::dirDown;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Dwell counter and car motion
    // ----------------------------------------------------------------------

    // One check cycle, then dwellCycles+1 cycles of dwell, over and over
    // The floor only steps at the end of a dwell in which the car was not busy
    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            busy         <= 1'b0;
            dwelling     <= 1'b0;
            dwellCount   <= '0;
            currentFloor <= '0;
        end else if (dwelling) begin
            if (dwellCount == elevatorPkg::dwellCycles) begin
                busy       <= 1'b0;
                dwelling   <= 1'b0;
                dwellCount <= '0;
                // Step one floor toward the target
                if (!busy && (direction == elevatorPkg::dirUp)
                        && (targetFloor > currentFloor)) begin
                    currentFloor <= currentFloor + 1'b1;
                end else if (!busy && (direction == elevatorPkg::dirDown)
                        && (targetFloor < currentFloor)) begin
                    currentFloor <= currentFloor - 1'b1;
                end
            end else begin
                dwellCount <= dwellCount + 1'b1;
            end
        end else begin
            // Check cycle, the car stops here if this floor has a call
            if (pending[currentFloor]) begin
                busy <= 1'b1;
            end
            dwelling <= 1'b1;
        end
    end

endmodule

/* rtl/elevatorPkg.sv */
package elevatorPkg;

    // ----------------------------------------------------------------------
    // Building geometry
    // ----------------------------------------------------------------------

    // Five floors numbered 0 to 4
    localparam int numFloors = 5;

    // Bits needed to hold a floor number
    localparam int floorWidth = 3;

    // ----------------------------------------------------------------------
    // Travel direction codes
    // ----------------------------------------------------------------------

    localparam int dirWidth = 2;

    // The car is parked with nothing to serve
    localparam logic [dirWidth-1:0] dirIdle = 2'd0;
    // The target lies above the car
    localparam logic [dirWidth-1:0] dirUp = 2'd1;
    // The target lies below the car
    localparam logic [dirWidth-1:0] dirDown = 2'd2;

    // Clock cycles the car spends at a floor before it may move on
    localparam logic [7:0] dwellCycles = 8'd250;

    // ----------------------------------------------------------------------
    // Seven-segment patterns, active low, bit order g..a
    // ----------------------------------------------------------------------

    // Digits 0 to 4, one entry per floor
    localparam logic [6:0] floorGlyph [numFloors] = '{
        7'b1000000,
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001
    };

    // Indexed by direction code: idle is a bar, up lights a b f, down lights c d e
    localparam logic [6:0] dirGlyph [3] = '{
        7'b0111111,
        7'b1011100,
        7'b1100011
    };

endpackage

/* rtl/elevatorTop.sv */
`timescale 1ns/1ps

module elevatorTop (
    input  logic                                clk_in,
    input  logic                                rst,
    input  logic [elevatorPkg::numFloors-1:0]   hallPress,
    input  logic [elevatorPkg::numFloors-1:0]   hallUp,
    input  logic [elevatorPkg::numFloors-1:0]   carButton,
    output logic [elevatorPkg::numFloors-1:0]   hallLamp,
    output logic [elevatorPkg::numFloors-1:0]   carLamp,
    output logic                                busy,
    output logic [6:0]                          floorSegments,
    output logic [6:0]                          directionSegments
);

    // Car state shared by the call registers and the display
    logic [elevatorPkg::floorWidth-1:0] currentFloor;
    logic [elevatorPkg::floorWidth-1:0] targetFloor;
    logic [elevatorPkg::dirWidth-1:0]   direction;

    // ----------------------------------------------------------------------
    // Call registers, whose pending bits are the lamps
    // ----------------------------------------------------------------------

    hallCallRegister i_hallCallRegister (
        .clk_in       (clk_in),
        .rst          (rst),
        .hallPress    (hallPress),
        .hallUp       (hallUp),
        .currentFloor (currentFloor),
        .targetFloor  (targetFloor),
        .direction    (direction),
        .busy         (busy),
        .hallPending  (hallLamp)
    );

    carCallRegister i_carCallRegister (
        .clk_in       (clk_in),
        .rst          (rst),
        .carButton    (carButton),
        .currentFloor (currentFloor),
        .targetFloor  (targetFloor),
        .direction    (direction),
        .busy         (busy),
        .carPending   (carLamp)
    );

    // ----------------------------------------------------------------------
    // Motion control and display
    // ----------------------------------------------------------------------

    carController i_carController (
        .clk_in       (clk_in),
        .rst          (rst),
        .hallPending  (hallLamp),
        .carPending   (carLamp),
        .currentFloor (currentFloor),
        .targetFloor  (targetFloor),
        .direction    (direction),
        .busy         (busy)
    );

    floorDisplay i_floorDisplay (
        .clk_in            (clk_in),
        .rst               (rst),
        .currentFloor      (currentFloor),
        .direction         (direction),
        .floorSegments     (floorSegments),
        .directionSegments (directionSegments)
    );

endmodule

/* rtl/floorDisplay.sv */
`timescale 1ns/1ps

module floorDisplay (
    input  logic                                clk_in,
    input  logic                                rst,
    input  logic [elevatorPkg::floorWidth-1:0]  currentFloor,
    input  logic [elevatorPkg::dirWidth-1:0]    direction,
    output logic [6:0]                          floorSegments,
    output logic [6:0]                          directionSegments
);

    // ----------------------------------------------------------------------
    // Registered glyph lookups
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            floorSegments     <= elevatorPkg::floorGlyph[0];
            directionSegments <= elevatorPkg::dirGlyph[elevatorPkg::dirIdle];
        end else begin
            // Any floor number past the top shows the top digit
            if (currentFloor < elevatorPkg::numFloors) begin
                floorSegments <= elevatorPkg::floorGlyph[currentFloor];
            end else begin
                floorSegments <= elevatorPkg::floorGlyph[elevatorPkg::numFloors-1];
            end

            // The unused code falls through to the down arrow
            case (direction)
                elevatorPkg::dirIdle: begin
                    directionSegments <= elevatorPkg::dirGlyph[elevatorPkg::dirIdle];
                end
                elevatorPkg::dirUp: begin
                    directionSegments <= elevatorPkg::dirGlyph[elevatorPkg::dirUp];
                end
                default: begin
                    directionSegments <= elevatorPkg::dirGlyph[elevatorPkg::dirDown];
                end
            endcase
        end
    end

endmodule

/* rtl/hallCallRegister.sv */
`timescale 1ns/1ps

module hallCallRegister (
    input  logic                                clk_in,
    input  logic                                rst,
    input  logic [elevatorPkg::numFloors-1:0]   hallPress,
    input  logic [elevatorPkg::numFloors-1:0]   hallUp,
    input  logic [elevatorPkg::floorWidth-1:0]  currentFloor,
    input  logic [elevatorPkg::floorWidth-1:0]  targetFloor,
    input  logic [elevatorPkg::dirWidth-1:0]    direction,
    input  logic                                busy,
    output logic [elevatorPkg::numFloors-1:0]   hallPending
);

    // Direction each caller wants to travel, with the end floors fixed
    logic [elevatorPkg::numFloors-1:0] wantUp;

    // Floors whose press passes the acceptance rule this cycle
    logic [elevatorPkg::numFloors-1:0] accept;

    // ----------------------------------------------------------------------
    // Acceptance rule
    // ----------------------------------------------------------------------

    // A parked car takes any call away from its own floor
    // A moving car takes a call only if it lies on the way to the target
    // and the caller wants to go the same way the car is heading
    function automatic logic callAccepted(
        input logic [elevatorPkg::floorWidth-1:0] callFloor,
        input logic                               goingUp
    );
        logic idleOk;
        logic upOk;
        logic downOk;
        idleOk = (direction == elevatorPkg::dirIdle) && (currentFloor != callFloor);
        upOk   = (direction == elevatorPkg::dirUp) && (currentFloor < callFloor)
                 && (targetFloor >= callFloor) && goingUp;
        downOk = (direction == elevatorPkg::dirDown) && (currentFloor > callFloor)
                 && (targetFloor <= callFloor) && !goingUp;
        return idleOk || upOk || downOk;
    endfunction

    always_comb begin
        for (int f = 0; f < elevatorPkg::numFloors; f++) begin
            // The ground floor can only go up and the top floor only down
            if (f == 0) begin
                wantUp[f] = 1'b1;
            end else if (f == elevatorPkg::numFloors - 1) begin
                wantUp[f] = 1'b0;
            end else begin
                wantUp[f] = hallUp[f];
            end
            accept[f] = hallPress[f]
                        && callAccepted(elevatorPkg::floorWidth'(f), wantUp[f]);
        end
    end

    // ----------------------------------------------------------------------
    // Pending call bits, which are also the hall lamps
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_in or negedge rst) begin
        if (!rst) begin
            hallPending <= '0;
        end else begin
            for (int f = 0; f < elevatorPkg::numFloors; f++) begin
                // Serving the floor beats a fresh press on the same bit
                if (busy && (currentFloor == elevatorPkg::floorWidth'(f))) begin
                    hallPending[f] <= 1'b0;
                end else if (accept[f]) begin
                    hallPending[f] <= 1'b1;
                end
            end
        end
    end

endmodule

/* sim/elevatorTb.sv */
`timescale 1ns/1ps

module elevatorTb;

    logic                              clk_in;
    logic                              rst;
    logic [elevatorPkg::numFloors-1:0] hallPress;
    logic [elevatorPkg::numFloors-1:0] hallUp;
    logic [elevatorPkg::numFloors-1:0] carButton;
    logic [elevatorPkg::numFloors-1:0] hallLamp;
    logic [elevatorPkg::numFloors-1:0] carLamp;
    logic                              busy;
    logic [6:0]                        floorSegments;
    logic [6:0]                        directionSegments;

    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int unsigned lcgState   = 54450;

    tbClock i_clock (.clk_in(clk_in), .rst(rst));

    elevatorTop i_dut (
        .clk_in            (clk_in),
        .rst               (rst),
        .hallPress         (hallPress),
        .hallUp            (hallUp),
        .carButton         (carButton),
        .hallLamp          (hallLamp),
        .carLamp           (carLamp),
        .busy              (busy),
        .floorSegments     (floorSegments),
        .directionSegments (directionSegments)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // The whole run fits in forty dwell periods
    function automatic int cycleLimit();
        return 40 * (int'(elevatorPkg::dwellCycles) + 2);
    endfunction

    // The longest single wait is a four-floor trip with a stop plus some slack
    function automatic int waitLimit();
        return 7 * (int'(elevatorPkg::dwellCycles) + 2);
    endfunction

    // Violations of the car position rules on the controller
    function automatic int assertFailures();
        return i_dut.i_carController.i_carControllerChecks.failCount;
    endfunction

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return (lcgState >> 16) & 32'h7fff;
    endfunction

    // Reads a DUT output by its port name
    function automatic logic [6:0] sample(input string name);
        if (name == "floorSegments") begin
            return floorSegments;
        end else if (name == "directionSegments") begin
            return directionSegments;
        end else if (name == "busy") begin
            return {6'b0, busy};
        end else if (name == "carLamp") begin
            return {2'b0, carLamp};
        end
        return {2'b0, hallLamp};
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errorCount++;
        end
    endtask

    // Polls on falling edges until the output shows the value
    task automatic waitUntil(input string name, input logic [6:0] value);
        int waited;
        waited = 0;
        while ((sample(name) !== value) && (waited < waitLimit())) begin
            @(negedge clk_in);
            waited++;
        end
        if (sample(name) !== value) begin
            $display("Gave up after %0d cycles waiting for %s to show 0x%0h",
                     waited, name, value);
            errorCount++;
        end
    endtask

    // Button lines idle high, so a press is a short low pulse
    task automatic pressCarButton(input int floorNum);
        carButton[floorNum] = 1'b0;
        repeat (2) @(negedge clk_in);
        carButton[floorNum] = 1'b1;
        @(negedge clk_in);
    endtask

    // The car parks at the floor with every call served
    task automatic waitIdleAt(input int floorNum);
        waitUntil("directionSegments", elevatorPkg::dirGlyph[elevatorPkg::dirIdle]);
        compare("floorSegments", floorSegments, elevatorPkg::floorGlyph[floorNum]);
        compare("carLamp", carLamp, 0);
        compare("hallLamp", hallLamp, 0);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------

    task automatic checkResetState();
        compare("hallLamp", hallLamp, 0);
        compare("carLamp", carLamp, 0);
        compare("busy", busy, 0);
        compare("floorSegments", floorSegments, elevatorPkg::floorGlyph[0]);
        compare("directionSegments", directionSegments,
                elevatorPkg::dirGlyph[elevatorPkg::dirIdle]);
    endtask

    // The car goes from floor 0 to floor 3 and shows every floor on the way
    task automatic serveCarCallUp();
        pressCarButton(3);
        compare("carLamp", carLamp, 1 << 3);
        waitUntil("directionSegments", elevatorPkg::dirGlyph[elevatorPkg::dirUp]);
        for (int f = 1; f <= 3; f++) begin
            waitUntil("floorSegments", elevatorPkg::floorGlyph[f]);
        end
        waitUntil("busy", 1);
        compare("floorSegments", floorSegments, elevatorPkg::floorGlyph[3]);
        waitUntil("carLamp", 0);
        waitIdleAt(3);
    endtask

    // A held button and a release at the parked floor are both ignored
    task automatic checkEdgeQualification();
        carButton[3] = 1'b0;
        repeat (20) begin
            @(negedge clk_in);
            compare("carLamp", carLamp, 0);
        end
        carButton[3] = 1'b1;
        repeat (2) begin
            @(negedge clk_in);
            compare("carLamp", carLamp, 0);
        end
        // Only the release of another floor's button counts
        carButton[0] = 1'b0;
        repeat (20) begin
            @(negedge clk_in);
            compare("carLamp", carLamp, 0);
        end
        carButton[0] = 1'b1;
        @(negedge clk_in);
        compare("carLamp", carLamp, 1 << 0);
        waitUntil("directionSegments", elevatorPkg::dirGlyph[elevatorPkg::dirDown]);
        waitIdleAt(0);
    endtask

    // On the way up only an upward hall call at floor 2 is taken
    task automatic checkHallDirectionFilter();
        pressCarButton(4);
        compare("carLamp", carLamp, 1 << 4);
        waitUntil("directionSegments", elevatorPkg::dirGlyph[elevatorPkg::dirUp]);
        hallUp[2]    = 1'b0;
        hallPress[2] = 1'b1;
        repeat (4) begin
            @(negedge clk_in);
            compare("hallLamp", hallLamp, 0);
        end
        hallUp[2] = 1'b1;
        @(negedge clk_in);
        hallPress[2] = 1'b0;
        hallUp[2]    = 1'b0;
        compare("hallLamp", hallLamp, 1 << 2);
        // The first stop is floor 2, then the trip goes on to the top
        waitUntil("busy", 1);
        compare("floorSegments", floorSegments, elevatorPkg::floorGlyph[2]);
        waitUntil("hallLamp", 0);
        compare("carLamp", carLamp, 1 << 4);
        waitUntil("busy", 0);
        waitUntil("floorSegments", elevatorPkg::floorGlyph[3]);
        waitUntil("floorSegments", elevatorPkg::floorGlyph[4]);
        waitIdleAt(4);
    endtask

    // Car calls to generated floors with the car starting at the top floor
    task automatic serveRandomCalls();
        int pick;
        int curFloor;
        curFloor = elevatorPkg::numFloors - 1;
        for (int n = 0; n < 3; n++) begin
            pick = int'(nextRandom() % elevatorPkg::numFloors);
            pressCarButton(pick);
            if (pick == curFloor) begin
                compare("carLamp", carLamp, 0);
            end else begin
                compare("carLamp", carLamp, 1 << pick);
                if (pick > curFloor) begin
                    waitUntil("directionSegments",
                              elevatorPkg::dirGlyph[elevatorPkg::dirUp]);
                end else begin
                    waitUntil("directionSegments",
                              elevatorPkg::dirGlyph[elevatorPkg::dirDown]);
                end
                waitIdleAt(pick);
                curFloor = pick;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Run control
    // ----------------------------------------------------------------------

    always @(posedge clk_in) begin
        cycleCount++;
        if (cycleCount > cycleLimit()) begin
            errorCount = errorCount + assertFailures();
            $display("The run hit its limit of %0d cycles before the tests ended", cycleLimit());
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        hallPress = '0;
        hallUp    = '0;
        carButton = '1;
        wait (rst === 1'b1);
        @(negedge clk_in);
        checkResetState();
        serveCarCallUp();
        checkEdgeQualification();
        checkHallDirectionFilter();
        serveRandomCalls();
        repeat (4) @(negedge clk_in);
        errorCount = errorCount + assertFailures();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sim/elevatorTb_assert.sv */
`timescale 1ns/1ps

module carControllerChecks (
    input logic                               clk_in,
    input logic                               rst,
    input logic [elevatorPkg::floorWidth-1:0] currentFloor,
    input logic                               busy
);

    // Number of position rule violations seen so far
    int failCount = 0;

    // ----------------------------------------------------------------------
    // Car position rules
    // ----------------------------------------------------------------------

    // The car never leaves the building
    floorInRange: assert property (@(posedge clk_in) disable iff (!rst)
        currentFloor < elevatorPkg::numFloors)
        else begin
            $error("currentFloor %0d is past the top floor", currentFloor);
            failCount++;
        end

    // Each move is one floor up or one floor down
    singleFloorStep: assert property (@(posedge clk_in) disable iff (!rst)
        (currentFloor != $past(currentFloor)) |->
            ((currentFloor - $past(currentFloor)) == 1)
            || (($past(currentFloor) - currentFloor) == 1))
        else begin
            $error("currentFloor jumped from %0d to %0d", $past(currentFloor), currentFloor);
            failCount++;
        end

    // The car stands still while it serves a floor
    stillWhileBusy: assert property (@(posedge clk_in) disable iff (!rst)
        busy |=> $stable(currentFloor))
        else begin
            $error("currentFloor moved while busy was high");
            failCount++;
        end

endmodule

bind carController carControllerChecks i_carControllerChecks (
    .clk_in       (clk_in),
    .rst          (rst),
    .currentFloor (currentFloor),
    .busy         (busy)
);

/* sim/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk_in,
    output logic rst
);

    // Free-running clock with a 10 ns period
    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // Reset is held low for eight cycles and let go on a falling edge
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b1;
    end

endmodule

/* src.f */
rtl/elevatorPkg.sv
rtl/hallCallRegister.sv
rtl/carCallRegister.sv
rtl/carController.sv
rtl/floorDisplay.sv
rtl/elevatorTop.sv
sim/tbClock.sv
sim/elevatorTb_assert.sv
sim/elevatorTb.sv
